// File: sensor_rx_consts.svh
`ifndef SENSOR_RX_CONSTS_SVH
`define SENSOR_RX_CONSTS_SVH

// Serial word is start bit (1), ten data bits LSB first, stop bit (0).
`define WORD_BITS 12
`define DATA_BITS 10

// Data value repeated by the sensor while it trains the link.
`define TRAIN_WORD 10'h2A5

// An escape word announces that the next word is a sync code.
`define ESC_WORD 10'h3FF
`define CODE_FS 10'd1
`define CODE_LS 10'd2
`define CODE_LE 10'd3
`define CODE_FE 10'd4

// Consecutive training words at one phase before the link counts as locked.
`define LOCK_COUNT 4

`define FIFO_DEPTH 16

// Geometry the sensor is programmed for.
`define LINE_PIXELS 8
`define FRAME_LINES 4

`endif

// File: sensor_rx_pkg.sv
`include "sensor_rx_consts.svh"

package sensor_rx_pkg;

    typedef enum logic [2:0] {
        PIXEL       = 3'd0,
        FRAME_START = 3'd1,
        LINE_START  = 3'd2,
        LINE_END    = 3'd3,
        FRAME_END   = 3'd4
    } beat_kind_e;

    typedef struct packed {
        beat_kind_e            kind;
        logic [`DATA_BITS-1:0] data;
    } beat_t;

    typedef struct packed {
        logic [`DATA_BITS-1:0] data;
        logic                  sof;
        logic                  eol;
        logic                  eof;
    } pix_t;

    typedef struct packed {
        logic [7:0] lines;
        logic [7:0] short_lines;
        logic       bad_geometry;
    } frame_status_t;

    // True for the word values that follow an escape as sync codes.
    function automatic logic code_known(input logic [`DATA_BITS-1:0] code);
        return code inside {`CODE_FS, `CODE_LS, `CODE_LE, `CODE_FE};
    endfunction

    function automatic beat_kind_e code_kind(input logic [`DATA_BITS-1:0] code);
        case (code)
            `CODE_FS: return FRAME_START;
            `CODE_LS: return LINE_START;
            `CODE_LE: return LINE_END;
            `CODE_FE: return FRAME_END;
            default:  return PIXEL;
        endcase
    endfunction

endpackage

// File: lvds_deframer.sv
`timescale 1ns/100ps
`include "sensor_rx_consts.svh"

module lvds_deframer
    import sensor_rx_pkg::*;
(
    input  logic  frame_valid,
    input  logic  arst_n,
    input  logic  sdata,
    output beat_t beat,
    output logic  beat_valid,
    input  logic  beat_ready,
    output logic  locked,
    output logic  overflow
);

    localparam int PHASE_W = $clog2(`WORD_BITS);
    localparam int MATCH_W = $clog2(`LOCK_COUNT + 1);

    logic [`WORD_BITS-1:0] shift_q;
    logic [`WORD_BITS-1:0] win;
    logic [`DATA_BITS-1:0] word;
    logic [PHASE_W-1:0]    phase_q;
    logic [MATCH_W-1:0]    match_q;
    logic                  word_end;
    logic                  framed_ok;
    logic                  train_hit;
    logic                  locked_q;
    logic                  esc_q;
    logic                  in_line_q;
    logic                  emit;
    beat_t                 next_beat;
    beat_t                 beat_q;
    logic                  beat_valid_q;
    logic                  overflow_q;

    // The window includes the bit on sdata now, so a word is complete
    // in the cycle its stop bit is sampled.
    assign win       = {sdata, shift_q[`WORD_BITS-1:1]};
    assign word      = win[`DATA_BITS:1];     // Bit 0 holds the start bit.
    assign framed_ok = win[0] && !win[`WORD_BITS-1];
    assign train_hit = framed_ok && (word == `TRAIN_WORD);
    assign word_end  = (phase_q == PHASE_W'(`WORD_BITS - 1));

    // Word decoding once the link is locked.
    always_comb begin
        emit           = 1'b0;
        next_beat.kind = PIXEL;
        next_beat.data = word;
        if (locked_q && word_end && framed_ok) begin
            if (esc_q) begin
                emit           = code_known(word);   // Unknown codes after an escape are dropped.
                next_beat.kind = code_kind(word);
            end else if (word != `ESC_WORD && word != `TRAIN_WORD) begin
                emit = in_line_q;                     // Pixels outside a line are dropped.
            end
        end
    end

    always_ff @(posedge frame_valid or negedge arst_n) begin
        if (!arst_n) begin
            phase_q      <= '0;
            match_q      <= '0;
            locked_q     <= 1'b0;
            esc_q        <= 1'b0;
            in_line_q    <= 1'b0;
            beat_valid_q <= 1'b0;
            overflow_q   <= 1'b0;
        end else begin
            beat_valid_q <= emit;
            if (beat_valid_q && !beat_ready) begin
                overflow_q <= 1'b1;                   // The stream cannot wait, so the beat is gone.
            end

            phase_q <= word_end ? '0 : phase_q + 1'b1;

            if (!locked_q) begin
                esc_q     <= 1'b0;
                in_line_q <= 1'b0;
                // A first hit may land on any bit. Later hits must sit one word apart.
                if (train_hit && (match_q == '0 || word_end)) begin
                    phase_q <= '0;
                    if (match_q == MATCH_W'(`LOCK_COUNT - 1)) begin
                        locked_q <= 1'b1;
                        match_q  <= '0;
                    end else begin
                        match_q <= match_q + 1'b1;
                    end
                end else if (word_end) begin
                    match_q <= '0;
                end
            end else if (word_end) begin
                if (!framed_ok) begin
                    locked_q <= 1'b0;                 // Bad start or stop bit. Hunt again.
                end else if (esc_q) begin
                    esc_q <= 1'b0;
                    if (code_known(word)) begin
                        in_line_q <= (code_kind(word) == LINE_START);
                    end
                end else if (word == `ESC_WORD) begin
                    esc_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge frame_valid) begin
        shift_q <= win;
        if (emit) begin
            beat_q <= next_beat;
        end
    end

    assign beat       = beat_q;
    assign beat_valid = beat_valid_q;
    assign locked     = locked_q;
    assign overflow   = overflow_q;

endmodule

// File: pixel_fifo.sv
`timescale 1ns/100ps
`include "sensor_rx_consts.svh"

module pixel_fifo
    import sensor_rx_pkg::*;
#(
    parameter type payload_t = beat_t,
    parameter int  depth     = `FIFO_DEPTH
) (
    input  logic     frame_valid,
    input  logic     arst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    payload_t         mem [depth];
    payload_t         out_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] mem_cnt_q;
    logic [CNT_W:0]   fill;
    logic             out_valid_q;
    logic             load;
    logic             wr;
    logic             bypass;
    logic             mem_wr;
    logic             mem_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // The output register counts toward the depth.
    assign fill     = {1'b0, mem_cnt_q} + (CNT_W + 1)'(out_valid_q);
    assign in_ready = (fill < (CNT_W + 1)'(depth));

    assign load   = !out_valid_q || out_ready;
    assign wr     = in_valid && in_ready;
    assign bypass = load && (mem_cnt_q == '0);   // Empty FIFO writes go straight to the output.
    assign mem_wr = wr && !bypass;
    assign mem_rd = load && (mem_cnt_q != '0);

    always_ff @(posedge frame_valid or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            mem_cnt_q   <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (mem_rd) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({mem_wr, mem_rd})
                2'b10:   mem_cnt_q <= mem_cnt_q + 1'b1;
                2'b01:   mem_cnt_q <= mem_cnt_q - 1'b1;
                default: mem_cnt_q <= mem_cnt_q;
            endcase
            if (load) begin
                out_valid_q <= mem_rd || wr;
            end
        end
    end

    always_ff @(posedge frame_valid) begin
        if (mem_wr) begin
            mem[wr_ptr_q] <= in_data;
        end
        if (load) begin
            out_q <= (mem_cnt_q != '0) ? mem[rd_ptr_q] : in_data;
        end
    end

    assign out_data  = out_q;
    assign out_valid = out_valid_q;

endmodule

// File: frame_formatter.sv
`timescale 1ns/100ps
`include "sensor_rx_consts.svh"

module frame_formatter
    import sensor_rx_pkg::*;
(
    input  logic          frame_valid,
    input  logic          arst_n,
    input  beat_t         beat,
    input  logic          beat_valid,
    output logic          beat_ready,
    output pix_t          pix,
    output logic          pix_valid,
    input  logic          pix_ready,
    output logic          frame_done,
    output frame_status_t status
);

    logic                  out_free;
    logic                  take;
    logic                  release_px;
    logic                  line_short;
    logic                  hold_q;
    logic                  hold_sof_q;
    logic                  hold_eol_q;
    logic [`DATA_BITS-1:0] hold_data_q;
    logic                  sof_pend_q;
    logic                  fe_q;
    logic                  pix_valid_q;
    logic                  frame_done_q;
    logic [7:0]            pix_cnt_q;
    logic [7:0]            lines_q;
    logic [7:0]            short_q;
    pix_t                  pix_q;
    frame_status_t         status_q;

    function automatic logic [7:0] sat_inc(input logic [7:0] v);
        return (v == 8'hFF) ? v : v + 1'b1;
    endfunction

    assign out_free   = !pix_valid_q || pix_ready;
    assign beat_ready = out_free && !fe_q;        // No beats while a frame end is closing.
    assign take       = beat_valid && beat_ready;
    // A line end only marks the held pixel; the beat after it decides eof.
    assign release_px = take && hold_q && (beat.kind != LINE_END);
    assign line_short = (pix_cnt_q != 8'(`LINE_PIXELS));

    always_ff @(posedge frame_valid or negedge arst_n) begin
        if (!arst_n) begin
            hold_q       <= 1'b0;
            hold_sof_q   <= 1'b0;
            hold_eol_q   <= 1'b0;
            sof_pend_q   <= 1'b0;
            fe_q         <= 1'b0;
            pix_valid_q  <= 1'b0;
            frame_done_q <= 1'b0;
            pix_cnt_q    <= '0;
            lines_q      <= '0;
            short_q      <= '0;
        end else begin
            frame_done_q <= 1'b0;
            if (out_free) begin
                pix_valid_q <= release_px;
            end
            // Wait for the last pixel to leave before reporting the frame.
            if (fe_q && out_free) begin
                fe_q         <= 1'b0;
                frame_done_q <= 1'b1;
            end
            if (take) begin
                case (beat.kind)
                    PIXEL: begin
                        hold_q     <= 1'b1;
                        hold_sof_q <= sof_pend_q;
                        hold_eol_q <= 1'b0;
                        sof_pend_q <= 1'b0;
                        pix_cnt_q  <= sat_inc(pix_cnt_q);
                    end
                    LINE_END: begin
                        hold_eol_q <= 1'b1;
                        lines_q    <= sat_inc(lines_q);
                        if (line_short) begin
                            short_q <= sat_inc(short_q);
                        end
                    end
                    LINE_START: begin
                        hold_q    <= 1'b0;
                        pix_cnt_q <= '0;
                    end
                    FRAME_START: begin
                        hold_q     <= 1'b0;
                        sof_pend_q <= 1'b1;
                        lines_q    <= '0;
                        short_q    <= '0;
                    end
                    FRAME_END: begin
                        hold_q <= 1'b0;
                        fe_q   <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge frame_valid) begin
        if (take && beat.kind == PIXEL) begin
            hold_data_q <= beat.data;
        end
        if (release_px) begin
            pix_q.data <= hold_data_q;
            pix_q.sof  <= hold_sof_q;
            pix_q.eol  <= hold_eol_q;
            pix_q.eof  <= (beat.kind == FRAME_END);
        end
        if (take && beat.kind == FRAME_END) begin
            status_q.lines        <= lines_q;
            status_q.short_lines  <= short_q;
            status_q.bad_geometry <= (lines_q != 8'(`FRAME_LINES)) || (short_q != '0);
        end
    end

    assign pix        = pix_q;
    assign pix_valid  = pix_valid_q;
    assign frame_done = frame_done_q;
    assign status     = status_q;

endmodule

// File: sensor_rx_top.sv
`timescale 1ns/100ps
`include "sensor_rx_consts.svh"

module sensor_rx_top
    import sensor_rx_pkg::*;
(
    input  logic          frame_valid,
    input  logic          arst_n,
    input  logic          sdata,
    output pix_t          pix,
    output logic          pix_valid,
    input  logic          pix_ready,
    output logic          frame_done,
    output frame_status_t status,
    output logic          locked,
    output logic          overflow
);

    beat_t beat;
    logic  beat_valid;
    logic  beat_ready;
    beat_t fifo_beat;
    logic  fifo_valid;
    logic  fifo_ready;

    lvds_deframer u_deframer (
        .frame_valid (frame_valid),
        .arst_n      (arst_n),
        .sdata       (sdata),
        .beat        (beat),
        .beat_valid  (beat_valid),
        .beat_ready  (beat_ready),
        .locked      (locked),
        .overflow    (overflow)
    );

    // Absorbs the gaps when the pixel sink stalls.
    pixel_fifo #(
        .payload_t (beat_t),
        .depth     (`FIFO_DEPTH)
    ) u_fifo (
        .frame_valid (frame_valid),
        .arst_n      (arst_n),
        .in_data     (beat),
        .in_valid    (beat_valid),
        .in_ready    (beat_ready),
        .out_data    (fifo_beat),
        .out_valid   (fifo_valid),
        .out_ready   (fifo_ready)
    );

    frame_formatter u_formatter (
        .frame_valid (frame_valid),
        .arst_n      (arst_n),
        .beat        (fifo_beat),
        .beat_valid  (fifo_valid),
        .beat_ready  (fifo_ready),
        .pix         (pix),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .frame_done  (frame_done),
        .status      (status)
    );

endmodule

// File: sensor_rx_asserts.sv
`timescale 1ns/100ps

module sensor_rx_asserts
    import sensor_rx_pkg::*;
(
    input logic frame_valid,
    input logic arst_n,
    input pix_t pix,
    input logic pix_valid,
    input logic pix_ready,
    input logic frame_done,
    input logic beat_valid,
    input logic locked
);

    int fail_cnt = 0;   // Read by the testbench for its summary.

    // A stalled pixel must hold until the sink takes it.
    pix_hold: assert property (@(posedge frame_valid) disable iff (!arst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix))
    else begin
        fail_cnt++;
        $error("pix changed or dropped while stalled");
    end

    done_pulse: assert property (@(posedge frame_valid) disable iff (!arst_n)
        frame_done |=> !frame_done)
    else begin
        fail_cnt++;
        $error("frame_done high for two cycles in a row");
    end

    beat_locked: assert property (@(posedge frame_valid) disable iff (!arst_n)
        !(beat_valid && !locked))   // Beats only come from a locked link.
    else begin
        fail_cnt++;
        $error("beat_valid high while the link is unlocked");
    end

endmodule

// File: sensor_rx_tb.sv
`timescale 1ns/100ps
`include "sensor_rx_consts.svh"

module sensor_rx_tb
    import sensor_rx_pkg::*;
();

    // A frame is 52 words of 12 bits, so six tests stay well under 8000 cycles.
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int READY_HIGH     = 0;
    localparam int READY_RANDOM   = 1;
    localparam int READY_LOW      = 2;

    logic          frame_valid  = 1'b0;
    logic          arst_n       = 1'b0;
    logic          sdata        = 1'b0;
    logic          pix_ready    = 1'b1;
    pix_t          pix;
    logic          pix_valid;
    logic          frame_done;
    frame_status_t status;
    logic          locked;
    logic          overflow;
    integer        seed         = 32'h04c0_7e18;
    int            ready_mode   = READY_HIGH;
    int            cycle_cnt    = 0;
    int            err_cnt      = 0;
    int            test_cnt     = 0;
    int            fail_tests   = 0;
    int            pix_cnt      = 0;
    int            done_cnt     = 0;
    int            left_at_done = 0;
    pix_t          exp_q[$];
    pix_t          want;
    frame_status_t last_status;

    sensor_rx_top dut0 (.*);

    bind sensor_rx_top sensor_rx_asserts u_asserts (.*);

    always #50 frame_valid = ~frame_valid;

    always @(posedge frame_valid) begin
        case (ready_mode)
            READY_RANDOM: pix_ready <= 1'($random(seed));
            READY_LOW:    pix_ready <= 1'b0;
            default:      pix_ready <= 1'b1;
        endcase
    end

    always @(posedge frame_valid) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without reaching the end", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Outputs are sampled mid-cycle; a pixel with ready high is taken at the next edge.
    always @(negedge frame_valid) begin
        if (arst_n && frame_done) begin
            done_cnt++;
            last_status  = status;
            left_at_done = exp_q.size();   // The last pixel must already be gone.
        end
        if (arst_n && pix_valid && pix_ready) begin
            pix_cnt++;
            if (exp_q.size() == 0) begin
                note_failure("a pixel was accepted while none was expected");
            end else begin
                want = exp_q.pop_front();
                if (pix !== want) note_mismatch("pix", 32'(want), 32'(pix));
            end
        end
    end

    task automatic note_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        err_cnt++;
        $display("ERR %s expected 0x%0h got 0x%0h at %0t ns", name, exp, act, $time);
    endtask

    task automatic note_failure(input string msg);
        err_cnt++;
        $display("Error: %s at %0t ns", msg, $time);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // Start bit first, then data LSB first, then the stop bit.
    task automatic send_word(input logic [`DATA_BITS-1:0] data, input logic stop_bit);
        logic [`WORD_BITS-1:0] bits;
        bits = {stop_bit, data, 1'b1};
        for (int i = 0; i < `WORD_BITS; i++) begin
            @(posedge frame_valid);
            sdata <= bits[i];
        end
    endtask

    task automatic send_training(input int words);
        repeat (words) send_word(`TRAIN_WORD, 1'b0);
    endtask

    task automatic send_code(input logic [`DATA_BITS-1:0] code);
        send_word(`ESC_WORD, 1'b0);
        send_word(code, 1'b0);
    endtask

    function automatic logic [`DATA_BITS-1:0] pixel_value();
        logic [`DATA_BITS-1:0] v;
        v = 10'($unsigned($random(seed)) % 32'h3FF);
        if (v == `TRAIN_WORD) v = v + 10'd1;   // The deframer drops training values.
        return v;
    endfunction

    task automatic send_frame(input int short_line, input bit record);
        int   npix;
        pix_t p;
        send_code(`CODE_FS);
        for (int l = 0; l < `FRAME_LINES; l++) begin
            npix = (l == short_line) ? `LINE_PIXELS - 1 : `LINE_PIXELS;
            send_code(`CODE_LS);
            for (int i = 0; i < npix; i++) begin
                p.data = pixel_value();
                p.sof  = (l == 0 && i == 0);
                p.eol  = (i == npix - 1);
                p.eof  = (l == `FRAME_LINES - 1 && i == npix - 1);
                if (record) exp_q.push_back(p);
                send_word(p.data, 1'b0);
            end
            send_code(`CODE_LE);
        end
        send_code(`CODE_FE);
    endtask

    task automatic train_until_locked();
        int tries;
        tries = 0;
        send_training(`LOCK_COUNT);
        while (locked !== 1'b1 && tries < `LOCK_COUNT + 2) begin
            send_training(1);
            tries++;
        end
        if (locked !== 1'b1) note_failure("the link did not lock on the training pattern");
    endtask

    task automatic run_frame(input int short_line, input int mode);
        int         done0;
        logic [7:0] short_exp;
        done0     = done_cnt;
        short_exp = (short_line >= 0) ? 8'd1 : 8'd0;
        ready_mode <= mode;
        send_frame(short_line, 1'b1);
        while (done_cnt == done0) begin
            send_training(1);   // The link idles on training words while the frame drains.
        end
        ready_mode <= READY_HIGH;
        if (left_at_done != 0) begin
            note_failure("frame_done came while pixels were still expected");
        end
        if (last_status.lines !== 8'(`FRAME_LINES))
            note_mismatch("status.lines", `FRAME_LINES, 32'(last_status.lines));
        if (last_status.short_lines !== short_exp)
            note_mismatch("status.short_lines", 32'(short_exp), 32'(last_status.short_lines));
        if (last_status.bad_geometry !== (short_exp != 8'd0))
            note_mismatch("status.bad_geometry", 32'(short_exp != 8'd0),
                          32'(last_status.bad_geometry));
        if (overflow !== 1'b0) note_mismatch("overflow", 32'h0, 32'(overflow));
    endtask

    task automatic lock_test();
        int errs0;
        int junk;
        errs0 = err_cnt;
        if (locked !== 1'b0) note_mismatch("locked", 32'h0, 32'(locked));
        if (overflow !== 1'b0) note_mismatch("overflow", 32'h0, 32'(overflow));
        if (pix_valid !== 1'b0) note_mismatch("pix_valid", 32'h0, 32'(pix_valid));
        if (frame_done !== 1'b0) note_mismatch("frame_done", 32'h0, 32'(frame_done));
        junk = 1 + int'($unsigned($random(seed)) % 23);
        repeat (junk) begin
            @(posedge frame_valid);
            sdata <= 1'($random(seed));
        end
        train_until_locked();
        if (pix_cnt != 0) note_failure("a pixel came out during training");
        finish_test("lock", errs0);
    endtask

    task automatic clean_frame_test();
        int errs0;
        errs0 = err_cnt;
        run_frame(-1, READY_HIGH);
        finish_test("clean_frame", errs0);
    endtask

    task automatic back_pressure_test();
        int errs0;
        errs0 = err_cnt;
        run_frame(-1, READY_RANDOM);
        finish_test("back_pressure", errs0);
    endtask

    task automatic geometry_test();
        int errs0;
        errs0 = err_cnt;
        run_frame(2, READY_HIGH);
        finish_test("geometry", errs0);
    endtask

    task automatic framing_test();
        int errs0;
        errs0 = err_cnt;
        send_word(`TRAIN_WORD, 1'b1);   // Stop bit flipped to 1.
        send_training(1);
        if (locked !== 1'b0) note_failure("locked stayed high after a bad stop bit");
        train_until_locked();
        run_frame(-1, READY_HIGH);
        finish_test("framing", errs0);
    endtask

    task automatic overflow_test();
        int errs0;
        errs0 = err_cnt;
        ready_mode <= READY_LOW;
        send_training(2);
        send_frame(-1, 1'b0);
        send_training(2);
        if (overflow !== 1'b1) note_mismatch("overflow", 32'h1, 32'(overflow));
        send_training(4);
        if (overflow !== 1'b1) note_failure("overflow cleared without a reset");
        finish_test("overflow", errs0);
    endtask

    initial begin
        repeat (3) @(posedge frame_valid);
        arst_n <= 1'b1;

        lock_test();
        clean_frame_test();
        back_pressure_test();
        geometry_test();
        framing_test();
        overflow_test();

        $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 test_cnt, fail_tests, err_cnt, dut0.u_asserts.fail_cnt);
        if (err_cnt == 0 && fail_tests == 0 && dut0.u_asserts.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
sensor_rx_pkg.sv
lvds_deframer.sv
pixel_fifo.sv
frame_formatter.sv
sensor_rx_top.sv
sensor_rx_asserts.sv
sensor_rx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sensor_rx_tb \
    -f list.f -o sensor_rx_sim \
    && ./obj_dir/sensor_rx_sim +verilator+error+limit+100 | tee sim.log \
    || echo "build or simulation did not complete"
grep -q "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
